// ==== csr_pkg.sv ====
// Machine CSR unit shared definitions
package csr_pkg;

    ////////////////////////////////////////
    // Widths
    localparam int XLEN      = 32;
    localparam int COUNTER_W = 64;
    localparam int ECODE_W   = 4;

    typedef logic [11:0] csr_addr_t;

    ////////////////////////////////////////
    // Machine CSR addresses
    localparam csr_addr_t MSTATUS   = 12'h300;
    localparam csr_addr_t MISA      = 12'h301;
    localparam csr_addr_t MIE       = 12'h304;
    localparam csr_addr_t MTVEC     = 12'h305;
    localparam csr_addr_t MSCRATCH  = 12'h340;
    localparam csr_addr_t MEPC      = 12'h341;
    localparam csr_addr_t MCAUSE    = 12'h342;
    localparam csr_addr_t MIP       = 12'h344;
    localparam csr_addr_t MCYCLE    = 12'hB00;
    localparam csr_addr_t MINSTRET  = 12'hB02;
    localparam csr_addr_t MCYCLEH   = 12'hB80;
    localparam csr_addr_t MINSTRETH = 12'hB82;
    localparam csr_addr_t MHARTID   = 12'hF14;

    ////////////////////////////////////////
    // Constants and masks
    // MXL of 1 in the top bits, I and M extensions
    localparam logic [XLEN-1:0] MISA_VALUE  = 32'h4000_1100;
    localparam logic [XLEN-1:0] HART_ID     = 32'h0000_0000;
    localparam logic [XLEN-1:0] RESET_MTVEC = 32'h0000_0100;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // Interrupt codes, also the mip and mie bit positions
    localparam logic [ECODE_W-1:0] CODE_MSI = 4'd3;
    localparam logic [ECODE_W-1:0] CODE_MTI = 4'd7;
    localparam logic [ECODE_W-1:0] CODE_MEI = 4'd11;

    localparam logic [XLEN-1:0] MIE_MASK = 32'h0000_0888;

    // One bit per cause code
    localparam logic [15:0] MCAUSE_LEGAL_EXC = 16'h085D;
    localparam logic [15:0] MCAUSE_LEGAL_INT = 16'h0888;

    ////////////////////////////////////////
    // Types
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef struct packed {
        csr_op_t         op;
        csr_addr_t       addr;
        logic [XLEN-1:0] wdata;
    } csr_request_t;

    typedef enum logic [3:0] {
        SEL_NONE, SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC, SEL_MSCRATCH, SEL_MEPC,
        SEL_MCAUSE, SEL_MIP, SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
        SEL_MHARTID
    } csr_sel_t;

    typedef struct packed {
        csr_sel_t        sel;
        csr_op_t         op;
        logic [XLEN-1:0] wdata;
        logic            writable;
    } csr_decoded_t;

    // One-cycle write command
    typedef struct packed {
        logic            valid;
        csr_sel_t        sel;
        logic [XLEN-1:0] value;
    } csr_write_t;

    typedef struct packed {
        logic [XLEN-1:0] mstatus;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mip;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mscratch;
    } machine_csrs_t;

    typedef struct packed {
        logic               valid;
        logic [ECODE_W-1:0] code;
        logic [XLEN-1:0]    pc;
    } exception_t;

    typedef struct packed {
        logic software;
        logic timer;
        logic external;
    } irq_t;

endpackage

// ==== csr_decode_stage.sv ====
// CSR access decode stage
module csr_decode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  csr_pkg::csr_request_t request,
    output csr_pkg::csr_decoded_t decoded,
    output logic                  decoded_valid
);

    logic              req_prev;
    logic              req_rise;
    csr_pkg::csr_sel_t sel;

    // New access only on a low to high change of req
    assign req_rise = req & ~req_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_prev      <= 1'b0;
            decoded_valid <= 1'b0;
        end else begin
            req_prev      <= req;
            decoded_valid <= req_rise;
        end
    end

    ////////////////////////////////////////
    // Address to register select
    always_comb begin
        case (request.addr)
            csr_pkg::MSTATUS:   sel = csr_pkg::SEL_MSTATUS;
            csr_pkg::MISA:      sel = csr_pkg::SEL_MISA;
            csr_pkg::MIE:       sel = csr_pkg::SEL_MIE;
            csr_pkg::MTVEC:     sel = csr_pkg::SEL_MTVEC;
            csr_pkg::MSCRATCH:  sel = csr_pkg::SEL_MSCRATCH;
            csr_pkg::MEPC:      sel = csr_pkg::SEL_MEPC;
            csr_pkg::MCAUSE:    sel = csr_pkg::SEL_MCAUSE;
            csr_pkg::MIP:       sel = csr_pkg::SEL_MIP;
            csr_pkg::MCYCLE:    sel = csr_pkg::SEL_MCYCLE;
            csr_pkg::MCYCLEH:   sel = csr_pkg::SEL_MCYCLEH;
            csr_pkg::MINSTRET:  sel = csr_pkg::SEL_MINSTRET;
            csr_pkg::MINSTRETH: sel = csr_pkg::SEL_MINSTRETH;
            csr_pkg::MHARTID:   sel = csr_pkg::SEL_MHARTID;
            default:            sel = csr_pkg::SEL_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_rise) begin
            decoded.sel      <= sel;
            decoded.op       <= request.op;
            decoded.wdata    <= request.wdata;
            // Top address bits 11 mark a read-only CSR
            decoded.writable <= (request.addr[11:10] != 2'b11);
        end
    end

endmodule

// ==== csr_read_modify_stage.sv ====
// CSR read and modify stage
module csr_read_modify_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  csr_pkg::csr_decoded_t               decoded,
    input  logic                                decoded_valid,
    input  csr_pkg::machine_csrs_t              regs,
    input  logic [csr_pkg::COUNTER_W-1:0]       mcycle,
    input  logic [csr_pkg::COUNTER_W-1:0]       minstret,
    output logic [csr_pkg::XLEN-1:0]            old_value,
    output logic [csr_pkg::XLEN-1:0]            new_value,
    output csr_pkg::csr_sel_t                   sel,
    output logic                                writable,
    output logic                                stage_valid
);

    logic [csr_pkg::XLEN-1:0] current;
    logic [csr_pkg::XLEN-1:0] updated;

    ////////////////////////////////////////
    // Register read mux
    always_comb begin
        case (decoded.sel)
            csr_pkg::SEL_MSTATUS:   current = regs.mstatus;
            csr_pkg::SEL_MISA:      current = csr_pkg::MISA_VALUE;
            csr_pkg::SEL_MIE:       current = regs.mie;
            csr_pkg::SEL_MTVEC:     current = regs.mtvec;
            csr_pkg::SEL_MSCRATCH:  current = regs.mscratch;
            csr_pkg::SEL_MEPC:      current = regs.mepc;
            csr_pkg::SEL_MCAUSE:    current = regs.mcause;
            csr_pkg::SEL_MIP:       current = regs.mip;
            csr_pkg::SEL_MCYCLE:    current = mcycle[31:0];
            csr_pkg::SEL_MCYCLEH:   current = mcycle[63:32];
            csr_pkg::SEL_MINSTRET:  current = minstret[31:0];
            csr_pkg::SEL_MINSTRETH: current = minstret[63:32];
            csr_pkg::SEL_MHARTID:   current = csr_pkg::HART_ID;
            default:                current = '0;
        endcase
    end

    // Operation on the old value
    always_comb begin
        case (decoded.op)
            csr_pkg::CSR_RW: updated = decoded.wdata;
            csr_pkg::CSR_RS: updated = current | decoded.wdata;
            csr_pkg::CSR_RC: updated = current & ~decoded.wdata;
            default:         updated = current;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= decoded_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (decoded_valid) begin
            old_value <= current;
            new_value <= updated;
            sel       <= decoded.sel;
            writable  <= decoded.writable;
        end
    end

endmodule

// ==== csr_commit_stage.sv ====
// CSR commit stage and handshake return
module csr_commit_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic [csr_pkg::XLEN-1:0] old_value,
    input  logic [csr_pkg::XLEN-1:0] new_value,
    input  csr_pkg::csr_sel_t        sel,
    input  logic                     writable,
    input  logic                     stage_valid,
    output csr_pkg::csr_write_t      wr,
    output logic                     ack,
    output logic [csr_pkg::XLEN-1:0] rdata
);

    ////////////////////////////////////////
    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            wr.valid <= 1'b0;
        end else begin
            // Write pulse lasts one cycle
            wr.valid <= stage_valid & writable & (sel != csr_pkg::SEL_NONE);
            if (stage_valid) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Payload
    always_ff @(posedge clk) begin
        if (stage_valid) begin
            wr.sel   <= sel;
            wr.value <= new_value;
            rdata    <= old_value;
        end
    end

endmodule

// ==== csr_machine_regs.sv ====
// Machine trap registers
module csr_machine_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_write_t      wr,
    input  csr_pkg::exception_t      exception,
    input  logic                     interrupt_taken,
    input  logic                     mret,
    input  csr_pkg::irq_t            irq,
    output csr_pkg::machine_csrs_t   regs,
    output logic                     interrupt_pending,
    output logic [csr_pkg::XLEN-1:0] trap_vector,
    output logic [csr_pkg::XLEN-1:0] epc
);

    logic                        status_mie;
    logic                        status_mpie;
    logic [csr_pkg::XLEN-1:0]    mie_r;
    logic [csr_pkg::XLEN-1:0]    mip_r;
    logic [csr_pkg::XLEN-1:0]    mtvec_r;
    logic [csr_pkg::XLEN-1:0]    mepc_r;
    logic [csr_pkg::XLEN-1:0]    mcause_r;
    logic [csr_pkg::XLEN-1:0]    mscratch_r;
    logic [csr_pkg::XLEN-1:0]    mstatus_word;
    logic [csr_pkg::XLEN-1:0]    pending_bits;
    logic [csr_pkg::ECODE_W-1:0] irq_code;
    logic [csr_pkg::ECODE_W-1:0] wr_code;
    logic                        mcause_legal;
    logic                        trap;

    assign trap    = exception.valid | interrupt_taken;
    assign wr_code = wr.value[csr_pkg::ECODE_W-1:0];

    ////////////////////////////////////////
    // mstatus, trap entry and mret win over a write
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
        end else if (trap) begin
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
        end else if (mret) begin
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
        end else if (wr.valid && wr.sel == csr_pkg::SEL_MSTATUS) begin
            status_mie  <= wr.value[csr_pkg::MSTATUS_MIE];
            status_mpie <= wr.value[csr_pkg::MSTATUS_MPIE];
        end
    end

    always_comb begin
        mstatus_word = '0;
        mstatus_word[csr_pkg::MSTATUS_MIE]  = status_mie;
        mstatus_word[csr_pkg::MSTATUS_MPIE] = status_mpie;
    end

    ////////////////////////////////////////
    // mie, mip, mtvec, mscratch
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_r      <= '0;
            mip_r      <= '0;
            mtvec_r    <= csr_pkg::RESET_MTVEC;
            mscratch_r <= '0;
        end else begin
            // mip mirrors the interrupt lines one cycle late
            mip_r                    <= '0;
            mip_r[csr_pkg::CODE_MSI] <= irq.software;
            mip_r[csr_pkg::CODE_MTI] <= irq.timer;
            mip_r[csr_pkg::CODE_MEI] <= irq.external;
            if (wr.valid && wr.sel == csr_pkg::SEL_MIE) begin
                mie_r <= wr.value & csr_pkg::MIE_MASK;
            end
            if (wr.valid && wr.sel == csr_pkg::SEL_MTVEC) begin
                mtvec_r <= {wr.value[csr_pkg::XLEN-1:2], 2'b00};
            end
            if (wr.valid && wr.sel == csr_pkg::SEL_MSCRATCH) begin
                mscratch_r <= wr.value;
            end
        end
    end

    ////////////////////////////////////////
    // mepc and mcause
    assign mcause_legal = wr.value[csr_pkg::XLEN-1] ? csr_pkg::MCAUSE_LEGAL_INT[wr_code]
                                                    : csr_pkg::MCAUSE_LEGAL_EXC[wr_code];

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_r   <= '0;
            mcause_r <= '0;
        end else begin
            if (exception.valid) begin
                mepc_r <= {exception.pc[csr_pkg::XLEN-1:2], 2'b00};
            end else if (wr.valid && wr.sel == csr_pkg::SEL_MEPC) begin
                mepc_r <= {wr.value[csr_pkg::XLEN-1:2], 2'b00};
            end
            if (interrupt_taken) begin
                mcause_r <= {1'b1, 27'b0, irq_code};
            end else if (exception.valid) begin
                mcause_r <= {1'b0, 27'b0, exception.code};
            end else if (wr.valid && wr.sel == csr_pkg::SEL_MCAUSE && mcause_legal) begin
                mcause_r <= {wr.value[csr_pkg::XLEN-1], 27'b0, wr_code};
            end
        end
    end

    ////////////////////////////////////////
    // Interrupt priority, external then software then timer
    assign pending_bits = mip_r & mie_r;

    always_comb begin
        if (pending_bits[csr_pkg::CODE_MEI]) begin
            irq_code = csr_pkg::CODE_MEI;
        end else if (pending_bits[csr_pkg::CODE_MSI]) begin
            irq_code = csr_pkg::CODE_MSI;
        end else begin
            irq_code = csr_pkg::CODE_MTI;
        end
    end

    assign interrupt_pending = (|pending_bits) & status_mie;

    assign regs.mstatus  = mstatus_word;
    assign regs.mie      = mie_r;
    assign regs.mip      = mip_r;
    assign regs.mtvec    = mtvec_r;
    assign regs.mepc     = mepc_r;
    assign regs.mcause   = mcause_r;
    assign regs.mscratch = mscratch_r;
    assign trap_vector   = mtvec_r;
    assign epc           = mepc_r;

endmodule

// ==== csr_counters.sv ====
// Cycle and retired instruction counters
module csr_counters (
    input  logic                          clk,
    input  logic                          rst,
    input  csr_pkg::csr_write_t           wr,
    input  logic [1:0]                    retire_count,
    output logic [csr_pkg::COUNTER_W-1:0] mcycle,
    output logic [csr_pkg::COUNTER_W-1:0] minstret
);

    logic cycle_lo_wr;
    logic cycle_hi_wr;
    logic ret_lo_wr;
    logic ret_hi_wr;

    assign cycle_lo_wr = wr.valid && wr.sel == csr_pkg::SEL_MCYCLE;
    assign cycle_hi_wr = wr.valid && wr.sel == csr_pkg::SEL_MCYCLEH;
    assign ret_lo_wr   = wr.valid && wr.sel == csr_pkg::SEL_MINSTRET;
    assign ret_hi_wr   = wr.valid && wr.sel == csr_pkg::SEL_MINSTRETH;

    ////////////////////////////////////////
    // A half-word write holds the count for that cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
        end else if (cycle_lo_wr) begin
            mcycle[31:0] <= wr.value;
        end else if (cycle_hi_wr) begin
            mcycle[63:32] <= wr.value;
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (ret_lo_wr) begin
            minstret[31:0] <= wr.value;
        end else if (ret_hi_wr) begin
            minstret[63:32] <= wr.value;
        end else begin
            minstret <= minstret + csr_pkg::COUNTER_W'(retire_count);
        end
    end

endmodule

// ==== csr_unit.sv ====
// Machine CSR unit top level
module csr_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  csr_pkg::csr_request_t    request,
    output logic                     ack,
    output logic [csr_pkg::XLEN-1:0] rdata,
    input  csr_pkg::exception_t      exception,
    input  logic                     interrupt_taken,
    input  logic                     mret,
    input  csr_pkg::irq_t            irq,
    input  logic [1:0]               retire_count,
    output logic                     interrupt_pending,
    output logic [csr_pkg::XLEN-1:0] trap_vector,
    output logic [csr_pkg::XLEN-1:0] epc
);

    csr_pkg::csr_decoded_t         decoded;
    logic                          decoded_valid;
    csr_pkg::machine_csrs_t        regs;
    logic [csr_pkg::COUNTER_W-1:0] mcycle;
    logic [csr_pkg::COUNTER_W-1:0] minstret;
    logic [csr_pkg::XLEN-1:0]      old_value;
    logic [csr_pkg::XLEN-1:0]      new_value;
    csr_pkg::csr_sel_t             sel;
    logic                          writable;
    logic                          stage_valid;
    csr_pkg::csr_write_t           wr;

    ////////////////////////////////////////
    // Access pipeline
    csr_decode_stage u_decode (
        .clk(clk), .rst(rst), .req(req), .request(request),
        .decoded(decoded), .decoded_valid(decoded_valid)
    );

    csr_read_modify_stage u_read_modify (
        .clk(clk), .rst(rst), .decoded(decoded), .decoded_valid(decoded_valid),
        .regs(regs), .mcycle(mcycle), .minstret(minstret),
        .old_value(old_value), .new_value(new_value), .sel(sel),
        .writable(writable), .stage_valid(stage_valid)
    );

    csr_commit_stage u_commit (
        .clk(clk), .rst(rst), .req(req), .old_value(old_value),
        .new_value(new_value), .sel(sel), .writable(writable),
        .stage_valid(stage_valid), .wr(wr), .ack(ack), .rdata(rdata)
    );

    ////////////////////////////////////////
    // Register blocks
    csr_machine_regs u_machine_regs (
        .clk(clk), .rst(rst), .wr(wr), .exception(exception),
        .interrupt_taken(interrupt_taken), .mret(mret), .irq(irq), .regs(regs),
        .interrupt_pending(interrupt_pending), .trap_vector(trap_vector), .epc(epc)
    );

    csr_counters u_counters (
        .clk(clk), .rst(rst), .wr(wr), .retire_count(retire_count),
        .mcycle(mcycle), .minstret(minstret)
    );

endmodule

// ==== csr_unit_assert.sv ====
// CSR unit handshake assertions
module csr_unit_assert (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack
);
    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////
    // Four-phase handshake rules

    // No ack without a request behind it
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) (!req && !ack) |=> !ack
    ) else $error("ack rose while req was low");

    req_waits_for_ack_low: assert property (
        @(posedge clk) disable iff (rst) $rose(req) |-> !ack
    ) else $error("req rose while ack was still high");

    // Held until the requester lets go
    ack_holds: assert property (
        @(posedge clk) disable iff (rst) (ack && req) |=> ack
    ) else $error("ack fell before req was released");

endmodule

bind csr_unit csr_unit_assert i_handshake_assert (
    .clk(clk),
    .rst(rst),
    .req(req),
    .ack(ack)
);

// ==== tb_csr_unit.sv ====
// CSR unit testbench
module tb_csr_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 8;
    localparam int NUM_ACCESSES   = 60;
    localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 20 + 200;
    localparam int ACK_LIMIT      = 20;
    localparam int MAX_CHECKS     = 512;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  req;
    csr_pkg::csr_request_t request;
    logic                  ack;
    logic [31:0]           rdata;
    csr_pkg::exception_t   exception;
    logic                  interrupt_taken;
    logic                  mret;
    csr_pkg::irq_t         irq;
    logic [1:0]            retire_count;
    logic                  interrupt_pending;
    logic [31:0]           trap_vector;
    logic [31:0]           epc;

    // Reference model of the machine registers
    logic [31:0]   m_mstatus;
    logic [31:0]   m_mie;
    logic [31:0]   m_mtvec;
    logic [31:0]   m_mepc;
    logic [31:0]   m_mcause;
    logic [31:0]   m_mscratch;
    csr_pkg::irq_t m_irq;

    // Checks posted by the stimulus, consumed by the compare process
    string       name_arr [MAX_CHECKS];
    logic [31:0] exp_arr [MAX_CHECKS];
    logic [31:0] act_arr [MAX_CHECKS];
    int          n_posted;
    int          n_checked = 0;
    int          compare_errors = 0;
    int          other_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    csr_unit i_dut (
        .clk(clk), .rst(rst), .req(req), .request(request), .ack(ack), .rdata(rdata),
        .exception(exception), .interrupt_taken(interrupt_taken), .mret(mret), .irq(irq),
        .retire_count(retire_count), .interrupt_pending(interrupt_pending),
        .trap_vector(trap_vector), .epc(epc)
    );

    ////////////////////////////////////////
    // Reference model
    function automatic logic [31:0] csr_expect(input csr_pkg::csr_addr_t addr,
            input csr_pkg::csr_op_t op, input logic [31:0] wdata, output logic [31:0] next);
        logic [31:0] old;
        logic [31:0] raw;
        logic [3:0]  code;
        logic        legal;
        case (addr)
            csr_pkg::MSTATUS:  old = m_mstatus;
            csr_pkg::MIE:      old = m_mie;
            csr_pkg::MTVEC:    old = m_mtvec;
            csr_pkg::MEPC:     old = m_mepc;
            csr_pkg::MCAUSE:   old = m_mcause;
            csr_pkg::MSCRATCH: old = m_mscratch;
            csr_pkg::MIP:      old = {20'd0, m_irq.external, 3'd0, m_irq.timer, 3'd0,
                                      m_irq.software, 3'd0};
            // RV32 with I and M
            csr_pkg::MISA:     old = 32'h4000_1100;
            csr_pkg::MHARTID:  old = 32'h0000_0000;
            default:           old = 32'h0000_0000;
        endcase
        case (op)
            csr_pkg::CSR_RW: raw = wdata;
            csr_pkg::CSR_RS: raw = old | wdata;
            default:         raw = old & ~wdata;
        endcase
        code = raw[3:0];
        if (raw[31]) begin
            legal = code inside {4'd3, 4'd7, 4'd11};
        end else begin
            legal = code inside {4'd0, 4'd2, 4'd3, 4'd4, 4'd6, 4'd11};
        end
        next = old;
        if (addr[11:10] != 2'b11) begin
            case (addr)
                csr_pkg::MSTATUS:  next = raw & 32'h0000_0088;
                csr_pkg::MIE:      next = raw & 32'h0000_0888;
                csr_pkg::MTVEC,
                csr_pkg::MEPC:     next = {raw[31:2], 2'b00};
                csr_pkg::MCAUSE:   next = legal ? {raw[31], 27'd0, code} : old;
                csr_pkg::MSCRATCH: next = raw;
                default:           next = old;
            endcase
        end
        return old;
    endfunction

    task automatic model_store(input csr_pkg::csr_addr_t addr, input logic [31:0] value);
        case (addr)
            csr_pkg::MSTATUS:  m_mstatus = value;
            csr_pkg::MIE:      m_mie = value;
            csr_pkg::MTVEC:    m_mtvec = value;
            csr_pkg::MEPC:     m_mepc = value;
            csr_pkg::MCAUSE:   m_mcause = value;
            csr_pkg::MSCRATCH: m_mscratch = value;
            default:           ;
        endcase
    endtask

    function automatic csr_pkg::csr_op_t random_op();
        logic [1:0] pick;
        pick = 2'($urandom_range(3, 1));
        return csr_pkg::csr_op_t'(pick);
    endfunction

    ////////////////////////////////////////
    // Compare process
    always @(posedge clk) begin
        while (n_checked < n_posted) begin
            if (exp_arr[n_checked] !== act_arr[n_checked]) begin
                $display("CHECK FAILED %s: expected %h actual %h", name_arr[n_checked],
                         exp_arr[n_checked], act_arr[n_checked]);
                compare_errors++;
            end
            n_checked++;
        end
    end

    task automatic post_compare(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (n_posted < MAX_CHECKS) begin
            name_arr[n_posted] = name;
            exp_arr[n_posted]  = expected;
            act_arr[n_posted]  = actual;
            n_posted++;
        end else begin
            $display("Check table is full, check %s was dropped", name);
            other_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus tasks, all entered 1 ns after a rising edge
    task automatic csr_access(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] data);
        int edges;
        edges = 0;
        request.op    = op;
        request.addr  = addr;
        request.wdata = wdata;
        req           = 1'b1;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (!ack && edges < ACK_LIMIT);
        if (!ack) begin
            $display("Handshake timeout, ack never rose for address %h", addr);
            other_errors++;
        end else begin
            post_compare("ack_rise_delay", 32'd3, 32'(edges));
        end
        data = rdata;
        req  = 1'b0;
        @(posedge clk);
        #1;
        post_compare("ack_fall", 32'd0, {31'd0, ack});
    endtask

    task automatic check_csr(input string name, input csr_pkg::csr_op_t op,
                             input csr_pkg::csr_addr_t addr, input logic [31:0] wdata);
        logic [31:0] exp_read;
        logic [31:0] exp_next;
        logic [31:0] got;
        exp_read = csr_expect(addr, op, wdata, exp_next);
        csr_access(op, addr, wdata, got);
        post_compare(name, exp_read, got);
        model_store(addr, exp_next);
    endtask

    task automatic pulse_exception(input logic [3:0] code, input logic [31:0] pc);
        exception.valid = 1'b1;
        exception.code  = code;
        exception.pc    = pc;
        @(posedge clk);
        #1;
        exception.valid = 1'b0;
        m_mepc    = {pc[31:2], 2'b00};
        m_mcause  = {28'd0, code};
        m_mstatus = {24'd0, m_mstatus[3], 3'd0, 1'b0, 3'd0};
    endtask

    task automatic take_interrupt();
        logic [3:0] code;
        // Priority is external, software, timer
        if (m_irq.external && m_mie[11]) begin
            code = 4'd11;
        end else if (m_irq.software && m_mie[3]) begin
            code = 4'd3;
        end else begin
            code = 4'd7;
        end
        interrupt_taken = 1'b1;
        @(posedge clk);
        #1;
        interrupt_taken = 1'b0;
        m_mcause  = {1'b1, 27'd0, code};
        m_mstatus = {24'd0, m_mstatus[3], 3'd0, 1'b0, 3'd0};
    endtask

    task automatic pulse_mret();
        mret = 1'b1;
        @(posedge clk);
        #1;
        mret = 1'b0;
        m_mstatus = {24'd0, 1'b1, 3'd0, m_mstatus[7], 3'd0};
    endtask

    task automatic wait_pending(input string name);
        int cycles;
        cycles = 0;
        while (interrupt_pending !== 1'b1 && cycles < 4) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (interrupt_pending !== 1'b1) begin
            $display("%s: interrupt_pending did not rise within 4 cycles", name);
            other_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    initial begin
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] data;
        int          sum;
        int          value;
        void'($urandom(32'hef954516));
        rst             = 1'b1;
        req             = 1'b0;
        request.op      = csr_pkg::CSR_RW;
        request.addr    = 12'h000;
        request.wdata   = 32'h0;
        exception       = '0;
        interrupt_taken = 1'b0;
        mret            = 1'b0;
        irq             = '0;
        retire_count    = 2'd0;
        n_posted        = 0;
        other_errors    = 0;
        m_mstatus       = 32'h0;
        m_mie           = 32'h0;
        m_mtvec         = csr_pkg::RESET_MTVEC;
        m_mepc          = 32'h0;
        m_mcause        = 32'h0;
        m_mscratch      = 32'h0;
        m_irq           = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        post_compare("reset_ack", 32'd0, {31'd0, ack});
        post_compare("reset_pending", 32'd0, {31'd0, interrupt_pending});

        // Random mscratch traffic
        check_csr("mscratch_initial", csr_pkg::CSR_RS, csr_pkg::MSCRATCH, 32'h0);
        for (int i = 0; i < 20; i++) begin
            check_csr("mscratch_random", random_op(), csr_pkg::MSCRATCH, $urandom());
        end

        // Masked and constant registers
        check_csr("mie_write", csr_pkg::CSR_RW, csr_pkg::MIE, 32'hFFFF_FFFF);
        check_csr("mie_mask", csr_pkg::CSR_RS, csr_pkg::MIE, 32'h0);
        check_csr("mtvec_write", csr_pkg::CSR_RW, csr_pkg::MTVEC, 32'h0000_2003);
        check_csr("mtvec_low_bits", csr_pkg::CSR_RS, csr_pkg::MTVEC, 32'h0);
        post_compare("trap_vector", m_mtvec, trap_vector);
        check_csr("mcause_legal_exc", csr_pkg::CSR_RW, csr_pkg::MCAUSE, 32'h0000_000B);
        check_csr("mcause_illegal_exc", csr_pkg::CSR_RW, csr_pkg::MCAUSE, 32'h0000_0005);
        check_csr("mcause_legal_int", csr_pkg::CSR_RW, csr_pkg::MCAUSE, 32'h8000_0007);
        check_csr("mcause_illegal_int", csr_pkg::CSR_RW, csr_pkg::MCAUSE, 32'h8000_0002);
        check_csr("mcause_readback", csr_pkg::CSR_RS, csr_pkg::MCAUSE, 32'h0);
        check_csr("misa_write", csr_pkg::CSR_RW, csr_pkg::MISA, 32'h0);
        check_csr("misa_const", csr_pkg::CSR_RS, csr_pkg::MISA, 32'h0);
        check_csr("mhartid_write", csr_pkg::CSR_RW, csr_pkg::MHARTID, 32'h1234_5678);
        check_csr("mhartid_const", csr_pkg::CSR_RS, csr_pkg::MHARTID, 32'h0);
        check_csr("unknown_write", csr_pkg::CSR_RW, 12'h7C0, 32'hDEAD_BEEF);
        check_csr("unknown_read", csr_pkg::CSR_RS, 12'h7C0, 32'h0);

        // Exception entry and mret
        check_csr("mstatus_enable", csr_pkg::CSR_RW, csr_pkg::MSTATUS, 32'h0000_0008);
        pulse_exception(4'd2, 32'h8000_1236);
        post_compare("exception_epc", m_mepc, epc);
        check_csr("exception_mcause", csr_pkg::CSR_RS, csr_pkg::MCAUSE, 32'h0);
        check_csr("exception_mstatus", csr_pkg::CSR_RS, csr_pkg::MSTATUS, 32'h0);
        pulse_mret();
        check_csr("mret_mstatus", csr_pkg::CSR_RS, csr_pkg::MSTATUS, 32'h0);

        // Interrupts, software beats timer, external beats both
        irq.software = 1'b1;
        irq.timer    = 1'b1;
        m_irq        = irq;
        wait_pending("pending_sw_timer");
        check_csr("mip_read", csr_pkg::CSR_RS, csr_pkg::MIP, 32'h0);
        take_interrupt();
        post_compare("pending_after_take", 32'd0, {31'd0, interrupt_pending});
        check_csr("interrupt_mcause_sw", csr_pkg::CSR_RS, csr_pkg::MCAUSE, 32'h0);
        pulse_mret();
        // Lines low first so pending falls
        irq   = '0;
        m_irq = irq;
        @(posedge clk);
        #1;
        post_compare("pending_cleared", 32'd0, {31'd0, interrupt_pending});
        // All three lines high at once
        irq.software = 1'b1;
        irq.timer    = 1'b1;
        irq.external = 1'b1;
        m_irq        = irq;
        wait_pending("pending_external");
        take_interrupt();
        check_csr("interrupt_mcause_ext", csr_pkg::CSR_RS, csr_pkg::MCAUSE, 32'h0);
        irq   = '0;
        m_irq = irq;
        pulse_mret();

        // Counters
        csr_access(csr_pkg::CSR_RW, csr_pkg::MINSTRET, 32'h0000_1000, data);
        csr_access(csr_pkg::CSR_RS, csr_pkg::MINSTRET, 32'h0, data);
        post_compare("minstret_readback", 32'h0000_1000, data);
        sum = 0;
        for (int i = 0; i < 16; i++) begin
            value        = $urandom_range(3, 0);
            retire_count = 2'(value);
            sum          = sum + value;
            @(posedge clk);
            #1;
        end
        retire_count = 2'd0;
        csr_access(csr_pkg::CSR_RS, csr_pkg::MINSTRET, 32'h0, data);
        post_compare("minstret_growth", 32'h0000_1000 + 32'(sum), data);
        csr_access(csr_pkg::CSR_RS, csr_pkg::MCYCLE, 32'h0, first);
        csr_access(csr_pkg::CSR_RS, csr_pkg::MCYCLE, 32'h0, second);
        post_compare("mcycle_increase", 32'd1, {31'd0, second > first});

        // Let the compare process drain
        repeat (2) @(posedge clk);
        #1;
        $display("Checks run: %0d, compare errors: %0d, other errors: %0d",
                 n_checked, compare_errors, other_errors);
        if (compare_errors == 0 && other_errors == 0 && n_checked == n_posted) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
csr_pkg.sv
csr_decode_stage.sv
csr_read_modify_stage.sv
csr_commit_stage.sv
csr_machine_regs.sv
csr_counters.sv
csr_unit.sv
csr_unit_assert.sv
tb_csr_unit.sv

// ==== Makefile ====
SRCS := $(wildcard *.sv)

all: run

obj_dir/Vtb_csr_unit: $(SRCS) csr_unit.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_csr_unit -f csr_unit.f

run: obj_dir/Vtb_csr_unit
	obj_dir/Vtb_csr_unit | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
